// File: all.f
pm_pkg.sv
univib.sv
run_ctl.sv
cycle_timer.sv
lg.sv
lk.sv
state_seq.sv
pm.sv
tb_pm.sv

// File: run.sh
#!/bin/sh
# build and run the pm testbench with Verilator, then scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pm -f all.f -o sim_pm \
	&& ./obj_dir/sim_pm > sim.log 2>&1 \
	|| echo "Errors found" >> sim.log
cat sim.log
if grep -q "Errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
grep -q "No errors" sim.log || exit 1
echo "simulation PASSED"

// File: tb_pm.sv
// testbench for the pm control unit
// applies a table of instructions and strobes and checks state order and counters
`timescale 1ns/1ps
`default_nettype none

module tb_pm;

	import pm_pkg::*;

	typedef struct packed {
		ir_word_u          ir;
		ctl_in_t           ctl;
		logic [3:0]        delay;
		logic              use_done;
		logic [3:0]        n;
		pm_state_t [7:0]   seq;
		logic [LG_W-1:0]   exp_lg;
		logic [LK_W-1:0]   exp_lk;
		logic              exp_run;
		logic              exp_wait;
	} row_t;

	localparam ctl_in_t NONE = 5'b00000;
	localparam ctl_in_t S_START = 5'b10000;
	localparam ctl_in_t S_STOP = 5'b01000;
	localparam ctl_in_t S_HLT = 5'b00100;
	localparam ctl_in_t S_CYCLE = 5'b00010;
	localparam ctl_in_t S_IRQ = 5'b00001;

	// one opcode per class
	localparam logic [5:0] OP_NORM = 6'b000001;
	localparam logic [5:0] OP_SHORT = 6'b100000;
	localparam logic [5:0] OP_SHIFT = 6'b110000;
	localparam logic [5:0] OP_GROUP = 6'b111000;

	logic            clk;
	logic            rst;
	ctl_in_t         ctl;
	ir_word_u        ir;
	logic            op_done;
	pm_state_t       state;
	logic            run;
	logic            waiting;
	logic            irq_ack;
	logic [LG_W-1:0] lg;
	logic [LK_W-1:0] lk;

	row_t        rows[$];
	logic [31:0] lfsr;
	int          model_lg;
	int          model_lk;
	int          limit_clocks;

	pm #(
		.KC_TICKS(3),
		.PC_TICKS(2)
	) uut (
		.__clk(clk),
		.rst(rst),
		.ctl(ctl),
		.ir(ir),
		.op_done(op_done),
		.state(state),
		.run(run),
		.waiting(waiting),
		.irq_ack(irq_ack),
		.lg(lg),
		.lk(lk)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_error();
		$display("Errors found");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic check_state(input pm_state_t got, input pm_state_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %s expected %s", $time, what, got.name(), exp.name());
			stop_on_error();
		end
	endtask

	task automatic check_count(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %b expected %b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic op_class_t class_of(input logic [5:0] op);
		if (op[5:4] == 2'b10)
			return CLS_SHORT;
		if (op[5:4] == 2'b11)
			return op[3] ? CLS_GROUP : CLS_SHIFT;
		return CLS_NORMAL;
	endfunction

	function automatic ir_word_u make_ir(input logic [5:0] op, input logic d,
			input logic [2:0] a, input logic [2:0] b, input logic [2:0] c);
		ir_word_u w;
		w.rg.op = op;
		w.rg.d = d;
		w.rg.a = a;
		w.rg.b = b;
		w.rg.c = c;
		return w;
	endfunction

	// expected path from P1 through P5 and the exit state
	task automatic add_row(input ir_word_u w, input ctl_in_t c, input int dly,
			input logic lead_p1, input logic lead_pi, input pm_state_t exit_st,
			input logic run_e, input logic wait_e);
		row_t      r;
		op_class_t cls;
		int        k;
		r = '0;
		cls = class_of(w.rg.op);
		r.ir = w;
		r.ctl = c;
		r.delay = 4'(dly);
		r.use_done = (cls == CLS_NORMAL) || (cls == CLS_SHORT);
		k = 0;
		if (lead_p1) begin
			r.seq[k] = P1;
			k++;
		end
		if (lead_pi) begin
			r.seq[k] = PI;
			k++;
			r.seq[k] = P1;
			k++;
		end
		if (cls == CLS_NORMAL && w.rg.c == 3'd0) begin
			r.seq[k] = P2;
			k++;
		end
		if (w.rg.b != 3'd0 && (cls == CLS_NORMAL || cls == CLS_SHORT)) begin
			r.seq[k] = P3;
			k++;
		end
		if (w.rg.d) begin
			r.seq[k] = P4;
			k++;
		end
		r.seq[k] = P5;
		k++;
		r.seq[k] = exit_st;
		k++;
		r.n = 4'(k);
		// counters after execute
		if (cls == CLS_GROUP) begin
			model_lg = (int'(w.rg.b) + int'(w.rg.a) + 1) % 8;
			model_lk = 0;
		end else if (cls == CLS_SHIFT) begin
			model_lk = 0;
		end
		r.exp_lg = LG_W'(model_lg);
		r.exp_lk = LK_W'(model_lk);
		r.exp_run = run_e;
		r.exp_wait = wait_e;
		rows.push_back(r);
	endtask

	task automatic apply_row(input int idx, input row_t r);
		pm_state_t last;
		int        waited;
		last = state;
		ir = r.ir;
		ctl = r.ctl;
		@(negedge clk);
		ctl = NONE;
		for (int k = 0; k < int'(r.n); k++) begin
			waited = 0;
			while (state == last) begin
				if (last == P5 && r.use_done && waited >= int'(r.delay))
					op_done = 1'b1;
				@(negedge clk);
				waited++;
			end
			op_done = 1'b0;
			check_state(state, r.seq[k], $sformatf("row %0d step %0d state", idx, k));
			if (state == PI)
				check_flag(irq_ack, 1'b1, $sformatf("row %0d irq_ack in PI", idx));
			last = state;
		end
		check_count({1'b0, lg}, {1'b0, r.exp_lg}, $sformatf("row %0d lg", idx));
		check_count(lk, r.exp_lk, $sformatf("row %0d lk", idx));
		check_flag(run, r.exp_run, $sformatf("row %0d run", idx));
		check_flag(waiting, r.exp_wait, $sformatf("row %0d waiting", idx));
	endtask

	initial begin
		wait (limit_clocks != 0);
		repeat (limit_clocks) @(posedge clk);
		$display("simulation timed out before all rows were applied");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] v;
		logic [31:0] d;
		rst = 1'b1;
		ctl = NONE;
		ir = '0;
		op_done = 1'b0;
		lfsr = 32'h4dc3_eec7;
		model_lg = 0;
		model_lk = 0;
		limit_clocks = 0;

		add_row(make_ir(OP_NORM, 1'b1, 3'd2, 3'd3, 3'd0), S_START, 2, 1'b1, 1'b0, P1, 1'b1, 1'b0);
		add_row(make_ir(OP_NORM, 1'b0, 3'd1, 3'd0, 3'd4), NONE, 1, 1'b0, 1'b0, P1, 1'b1, 1'b0);
		add_row(make_ir(OP_SHORT, 1'b0, 3'd0, 3'd2, 3'd0), NONE, 3, 1'b0, 1'b0, P1, 1'b1, 1'b0);
		add_row(make_ir(OP_SHIFT, 1'b0, 3'd0, 3'd0, 3'd5), NONE, 0, 1'b0, 1'b0, P1, 1'b1, 1'b0);
		add_row(make_ir(OP_GROUP, 1'b0, 3'd5, 3'd6, 3'd1), NONE, 0, 1'b0, 1'b0, P1, 1'b1, 1'b0);
		// halt and restart from P0
		add_row(make_ir(OP_NORM, 1'b0, 3'd0, 3'd0, 3'd7), S_HLT, 2, 1'b0, 1'b0, P0, 1'b0, 1'b1);
		add_row(make_ir(OP_NORM, 1'b0, 3'd3, 3'd0, 3'd2), S_START, 1, 1'b1, 1'b0, P1, 1'b1, 1'b0);
		add_row(make_ir(OP_NORM, 1'b0, 3'd0, 3'd0, 3'd1), S_STOP, 0, 1'b0, 1'b0, P0, 1'b0, 1'b0);
		add_row(make_ir(OP_NORM, 1'b0, 3'd0, 3'd0, 3'd3), S_CYCLE, 2, 1'b1, 1'b0, P0, 1'b0, 1'b0);
		add_row(make_ir(OP_NORM, 1'b0, 3'd4, 3'd0, 3'd6), S_START, 1, 1'b1, 1'b0, P1, 1'b1, 1'b0);
		add_row(make_ir(OP_NORM, 1'b0, 3'd0, 3'd0, 3'd2), S_IRQ, 1, 1'b0, 1'b1, P1, 1'b1, 1'b0);
		for (int i = 0; i < 8; i++) begin
			v = rand_bits(16);
			d = rand_bits(2);
			add_row(ir_word_u'(v[15:0]), NONE, int'(d[1:0]), 1'b0, 1'b0, P1, 1'b1, 1'b0);
		end
		limit_clocks = rows.size() * 40 + 200;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_state(state, P0, "state after reset");
		check_flag(run, 1'b0, "run after reset");
		check_flag(waiting, 1'b0, "waiting after reset");
		check_flag(irq_ack, 1'b0, "irq_ack after reset");
		check_count({1'b0, lg}, 4'd0, "lg after reset");
		check_count(lk, 4'd0, "lk after reset");

		foreach (rows[i])
			apply_row(i, rows[i]);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: pm.sv
// P-M microinstruction control unit, top level
// run control, cycle timing, state sequencing and the LG and LK counters
`timescale 1ns/1ps
`default_nettype none

module pm #(
	parameter int KC_TICKS = 3,
	parameter int PC_TICKS = 2
) (
	input  wire                     __clk,
	input  wire                     rst,
	input  wire pm_pkg::ctl_in_t    ctl,
	input  wire pm_pkg::ir_word_u   ir,
	input  wire                     op_done,
	output pm_pkg::pm_state_t       state,
	output logic                    run,
	output logic                    waiting,
	output logic                    irq_ack,
	output logic [pm_pkg::LG_W-1:0] lg,
	output logic [pm_pkg::LK_W-1:0] lk
);

	import pm_pkg::*;

	logic            pc;
	logic            pr;
	logic            przerw;
	logic            dpr;
	logic            dprzerw;
	logic            ekc;
	logic            ekc_p0;
	logic            in_p0;
	logic            lg_load;
	logic            lg_step;
	logic [LG_W-1:0] lg_preset;
	logic            lk_load;
	logic            lk_step;
	logic [LK_W-1:0] lk_count;
	logic            lk_zero;

	assign in_p0 = (state == P0);
	// interrupt taken during the PC that enters PI
	assign irq_ack = pc & przerw;

	run_ctl u_run_ctl (
		.__clk(__clk),
		.rst(rst),
		.ctl(ctl),
		.pc(pc),
		.przerw(przerw),
		.in_p0(in_p0),
		.run(run),
		.waiting(waiting),
		.dpr(dpr),
		.dprzerw(dprzerw),
		.ekc_p0(ekc_p0)
	);

	cycle_timer #(
		.KC_TICKS(KC_TICKS),
		.PC_TICKS(PC_TICKS)
	) u_cycle_timer (
		.__clk(__clk),
		.rst(rst),
		.ekc(ekc),
		.dpr(dpr),
		.dprzerw(dprzerw),
		.kc(),
		.pc(pc),
		.pr(pr),
		.przerw(przerw)
	);

	state_seq u_state_seq (
		.__clk(__clk),
		.rst(rst),
		.ir(ir),
		.op_done(op_done),
		.pc(pc),
		.pr(pr),
		.przerw(przerw),
		.ekc_p0(ekc_p0),
		.lk_zero(lk_zero),
		.state(state),
		.ekc(ekc),
		.lg_load(lg_load),
		.lg_step(lg_step),
		.lg_preset(lg_preset),
		.lk_load(lk_load),
		.lk_step(lk_step),
		.lk_count(lk_count)
	);

	lg cnt_lg (
		.__clk(__clk),
		.rst(rst),
		.load(lg_load),
		.step(lg_step),
		.preset(lg_preset),
		.lg(lg)
	);

	lk cnt_lk (
		.__clk(__clk),
		.rst(rst),
		.load(lk_load),
		.step(lk_step),
		.count(lk_count),
		.lk(lk),
		.zero(lk_zero)
	);

endmodule

`default_nettype wire

// File: state_seq.sv
// state sequencer: state register, next-state decision at PC,
// instruction class decode and execute-end detection
`timescale 1ns/1ps
`default_nettype none

module state_seq (
	input  wire                     __clk,
	input  wire                     rst,
	input  wire pm_pkg::ir_word_u   ir,
	input  wire                     op_done,
	input  wire                     pc,
	input  wire                     pr,
	input  wire                     przerw,
	input  wire                     ekc_p0,
	input  wire                     lk_zero,
	output pm_pkg::pm_state_t       state,
	output logic                    ekc,
	output logic                    lg_load,
	output logic                    lg_step,
	output logic [pm_pkg::LG_W-1:0] lg_preset,
	output logic                    lk_load,
	output logic                    lk_step,
	output logic [pm_pkg::LK_W-1:0] lk_count
);

	import pm_pkg::*;

	op_class_t cls;
	pm_state_t nxt;
	pm_state_t after_p1;
	pm_state_t after_p2;
	pm_state_t after_p3;
	logic      go_p2;
	logic      go_p3;
	logic      go_p4;
	logic      multi;
	logic      pc_d;
	logic      pc_rise;
	logic      pc_fall;
	logic      ended;
	logic      ekc_mid;
	logic      ekc_exec;

	// op 10xxxx short, 110xxx shift, 111xxx group, rest normal
	always_comb begin
		case (ir.rg.op[5:4])
			2'b10: cls = CLS_SHORT;
			2'b11: cls = ir.rg.op[3] ? CLS_GROUP : CLS_SHIFT;
			default: cls = CLS_NORMAL;
		endcase
	end

	assign multi = (cls == CLS_SHIFT) || (cls == CLS_GROUP);

	// argument word, B-mod, premod
	assign go_p2 = (cls == CLS_NORMAL) && (ir.rg.c == '0);
	assign go_p3 = (ir.rg.b != '0) && ((cls == CLS_NORMAL) || (cls == CLS_SHORT));
	assign go_p4 = ir.rg.d;

	assign after_p3 = go_p4 ? P4 : P5;
	assign after_p2 = go_p3 ? P3 : after_p3;
	assign after_p1 = go_p2 ? P2 : after_p2;

	always_comb begin
		if (przerw) begin
			nxt = PI;
		end else begin
			case (state)
				P1: nxt = after_p1;
				P2: nxt = after_p2;
				P3: nxt = after_p3;
				P4: nxt = P5;
				// end of instruction or stopped
				default: nxt = pr ? P1 : P0;
			endcase
		end
	end

	assign pc_rise = pc & ~pc_d;
	assign pc_fall = pc_d & ~pc;

	always_ff @(posedge __clk) begin
		if (rst) begin
			state <= P0;
			pc_d <= 1'b0;
			ended <= 1'b0;
		end else begin
			pc_d <= pc;
			if (pc_rise) begin
				state <= nxt;
				ended <= 1'b0;
			end else if (ekc) begin
				ended <= 1'b1;
			end
		end
	end

	// short states end right after their PC
	assign ekc_mid = pc_fall && (state inside {P1, P2, P3, P4, PI});
	// execute ends on the strobe, or when LK runs out
	assign ekc_exec = (state == P5) && !pc && !ended && (multi ? lk_zero : op_done);
	assign ekc = ekc_mid | ekc_exec | ekc_p0;

	// counters are set up on entry to P5
	assign lg_load = pc_rise && (nxt == P5) && (cls == CLS_GROUP);
	assign lk_load = pc_rise && (nxt == P5) && multi;
	assign lg_preset = ir.rg.b;
	assign lk_count = (cls == CLS_SHIFT) ? ir.sh.cnt : {1'b0, ir.rg.a} + 1'b1;

	assign lk_step = (state == P5) && multi && !lk_zero;
	assign lg_step = (state == P5) && (cls == CLS_GROUP) && !lk_zero;

	assert property (@(posedge __clk) disable iff (rst)
		state inside {P0, P1, P2, P3, P4, P5, PI});

endmodule

`default_nettype wire

// File: lk.sv
// LK step counter, loadable down-counter with zero flag
`timescale 1ns/1ps
`default_nettype none

module lk (
	input  wire                     __clk,
	input  wire                     rst,
	input  wire                     load,
	input  wire                     step,
	input  wire [pm_pkg::LK_W-1:0]  count,
	output logic [pm_pkg::LK_W-1:0] lk,
	output logic                    zero
);

	always_ff @(posedge __clk) begin
		if (rst)
			lk <= '0;
		else if (load)
			lk <= count;
		else if (step)
			lk <= lk - 1'b1;
	end

	assign zero = (lk == '0);

	// the sequencer stops stepping once the count runs out
	assert property (@(posedge __clk) disable iff (rst) step |-> !zero);

endmodule

`default_nettype wire

// File: lg.sv
// LG group counter, loadable up-counter wrapping modulo 8
`timescale 1ns/1ps
`default_nettype none

module lg (
	input  wire                     __clk,
	input  wire                     rst,
	input  wire                     load,
	input  wire                     step,
	input  wire [pm_pkg::LG_W-1:0]  preset,
	output logic [pm_pkg::LG_W-1:0] lg
);

	always_ff @(posedge __clk) begin
		if (rst)
			lg <= '0;
		else if (load)
			lg <= preset;
		else if (step)
			// wraps through 0 on its own
			lg <= lg + 1'b1;
	end

endmodule

`default_nettype wire

// File: cycle_timer.sv
// cycle timing: KC then PC one-shots, with the fetch and interrupt
// decisions taken at the end of KC
`timescale 1ns/1ps
`default_nettype none

module cycle_timer #(
	parameter int KC_TICKS = 1,
	parameter int PC_TICKS = 1
) (
	input  wire  __clk,
	input  wire  rst,
	input  wire  ekc,
	input  wire  dpr,
	input  wire  dprzerw,
	output logic kc,
	output logic pc,
	output logic pr,
	output logic przerw
);

	logic kc_d;
	logic kc_fall;

	univib #(.ticks(KC_TICKS)) vib_kc (
		.__clk(__clk),
		.rst(rst),
		.trig(ekc),
		.q(kc)
	);

	// PC starts on the trailing edge of KC
	assign kc_fall = kc_d & ~kc;

	univib #(.ticks(PC_TICKS)) vib_pc (
		.__clk(__clk),
		.rst(rst),
		.trig(kc_fall),
		.q(pc)
	);

	always_ff @(posedge __clk) begin
		if (rst) begin
			kc_d <= 1'b0;
			pr <= 1'b0;
			przerw <= 1'b0;
		end else begin
			kc_d <= kc;
			// follow requests during KC, frozen once KC drops
			if (kc) begin
				przerw <= dprzerw;
				pr <= dpr & ~dprzerw;
			end
		end
	end

	// cycle end and cycle start never overlap
	assert property (@(posedge __clk) disable iff (rst) !(kc && pc));

endmodule

`default_nettype wire

// File: run_ctl.sv
// run control: START, WAIT and CYCLE flip-flops
// and the fetch and interrupt requests they produce
`timescale 1ns/1ps
`default_nettype none

module run_ctl (
	input  wire              __clk,
	input  wire              rst,
	input  wire pm_pkg::ctl_in_t ctl,
	input  wire              pc,
	input  wire              przerw,
	input  wire              in_p0,
	output logic             run,
	output logic             waiting,
	output logic             dpr,
	output logic             dprzerw,
	output logic             ekc_p0
);

	logic start_q;
	logic wait_q;
	logic cycle_q;
	logic irq_q;
	logic irq_take;
	logic stpc_req;
	logic stpc_req_d;

	// interrupt is accepted at the PC that enters PI
	assign irq_take = pc & przerw;

	always_ff @(posedge __clk) begin
		if (rst) begin
			start_q <= 1'b0;
			wait_q <= 1'b0;
			cycle_q <= 1'b0;
			irq_q <= 1'b0;
			stpc_req_d <= 1'b0;
		end else begin
			stpc_req_d <= stpc_req;

			if (ctl.stop || ctl.hlt)
				start_q <= 1'b0;
			else if (ctl.start)
				start_q <= 1'b1;

			// halt only counts while running
			if (irq_take || ctl.stop || ctl.start)
				wait_q <= 1'b0;
			else if (ctl.hlt && start_q)
				wait_q <= 1'b1;

			// one pass through the instruction
			if (ctl.cycle)
				cycle_q <= 1'b1;
			else if (pc)
				cycle_q <= 1'b0;

			// irq strobe held as a pending level
			if (irq_take)
				irq_q <= 1'b0;
			else if (ctl.irq)
				irq_q <= 1'b1;
		end
	end

	assign run = start_q & ~wait_q;
	assign waiting = wait_q;
	assign dpr = run | cycle_q;
	assign dprzerw = irq_q & (start_q | cycle_q);

	// leave P0 once a request shows up after the last PC
	assign stpc_req = in_p0 & ~pc & (dpr | dprzerw);
	assign ekc_p0 = stpc_req & ~stpc_req_d;

endmodule

`default_nettype wire

// File: univib.sv
// one-shot, gives a pulse of a set number of clocks on a rising trigger
`timescale 1ns/1ps
`default_nettype none

module univib #(
	parameter int ticks = 1
) (
	input  wire  __clk,
	input  wire  rst,
	input  wire  trig,
	output logic q
);

	localparam int CW = $clog2(ticks + 1);

	logic [CW-1:0] cnt;
	logic          trig_d;
	logic          rise;

	assign rise = trig & ~trig_d;
	assign q = (cnt != '0);

	always_ff @(posedge __clk) begin
		if (rst) begin
			cnt <= '0;
			trig_d <= 1'b0;
		end else begin
			trig_d <= trig;
			// edges seen while the pulse runs are dropped
			if (rise && !q)
				cnt <= CW'(ticks);
			else if (q)
				cnt <= cnt - 1'b1;
		end
	end

	// a retrigger must not stretch the running pulse
	assert property (@(posedge __clk) disable iff (rst)
		(rise && q) |=> (cnt == $past(cnt) - 1'b1));

endmodule

`default_nettype wire

// File: pm_pkg.sv
// P-M microinstruction control unit
// shared types for cycle states, instruction classes, IR views and strobes
`default_nettype none

package pm_pkg;

	// counter widths
	localparam int LG_W = 3;
	localparam int LK_W = 4;

	// instruction cycle states, P0 is stopped
	typedef enum logic [2:0] {
		P0,
		P1,
		P2,
		P3,
		P4,
		P5,
		PI
	} pm_state_t;

	typedef enum logic [1:0] {
		CLS_NORMAL,
		CLS_SHORT,
		CLS_SHIFT,
		CLS_GROUP
	} op_class_t;

	// register view of IR
	typedef struct packed {
		logic [5:0] op;
		logic       d;
		logic [2:0] a;
		logic [2:0] b;
		logic [2:0] c;
	} ir_reg_t;

	// shift view, the low bits hold the count
	typedef struct packed {
		logic [5:0] op;
		logic       ext;
		logic       cnt_hi;
		logic [3:0] spare;
		logic [3:0] cnt;
	} ir_shift_t;

	typedef union packed {
		ir_reg_t   rg;
		ir_shift_t sh;
	} ir_word_u;

	// external strobes
	typedef struct packed {
		logic start;
		logic stop;
		logic hlt;
		logic cycle;
		logic irq;
	} ctl_in_t;

endpackage

`default_nettype wire
